//--- logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Instruction and data word width
`define WORD_W 32

// Default instruction queue entries, power of two
`define QUEUE_DEPTH 4

// Link register written by JAL
`define REG_RA 31

`endif

//--- logic/cpuTypesPkg.sv
`include "cpu_params.svh"

package cpuTypesPkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [4:0] regbits_t;

	// Standard MIPS major opcodes
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDIU = 6'b001001,
		SLTI  = 6'b001010,
		SLTIU = 6'b001011,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		XORI  = 6'b001110,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		HALT  = 6'b111111
	} opcode_t;

	typedef enum logic [5:0] {
		SLL  = 6'b000000,
		SRL  = 6'b000010,
		JR   = 6'b001000,
		ADDU = 6'b100001,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		XOR  = 6'b100110,
		NOR  = 6'b100111,
		SLT  = 6'b101010,
		SLTU = 6'b101011
	} funct_t;

	typedef enum logic [3:0] {
		ALU_SLL  = 4'd0,
		ALU_SRL  = 4'd1,
		ALU_ADD  = 4'd2,
		ALU_SUB  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_NOR  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} aluop_t;

	// Same word seen as R, I or J format
	typedef union packed {
		struct packed {
			opcode_t opcode;
			regbits_t rs;
			regbits_t rt;
			regbits_t rd;
			logic [4:0] shamt;
			funct_t funct;
		} rType;
		struct packed {
			opcode_t opcode;
			regbits_t rs;
			regbits_t rt;
			logic [15:0] imm16;
		} iType;
		struct packed {
			opcode_t opcode;
			logic [25:0] addr26;
		} jType;
	} instr_t;

endpackage

//--- logic/instrIntake.sv
`timescale 1ns/10ps

module instrIntake import cpuTypesPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input word_t inInstr,
	output logic inAck,
	output logic push,
	output word_t pushWord,
	input logic full
);

	// inAck doubles as the handshake state
	assign push = inReq && !inAck && !full;
	assign pushWord = inInstr;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			inAck <= 1'b0;
		end
		else if (push)
		begin
			inAck <= 1'b1;
		end
		else if (!inReq)
		begin
			// Fetch side has released the request
			inAck <= 1'b0;
		end
	end

	// Fetch side holds request and word until acknowledged
	reqHeld: assert property (
		@(posedge clk) disable iff (!rstN)
		inReq && !inAck |=> inAck || (inReq && $stable(inInstr))
	) else $error("instrIntake: request or word changed before ack");

endmodule

//--- logic/instrQueue.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module instrQueue import cpuTypesPkg::*;
#(
	parameter int DEPTH = `QUEUE_DEPTH
)
(
	input logic clk,
	input logic rstN,
	input logic push,
	input word_t pushWord,
	input logic pop,
	output word_t popWord,
	output logic full,
	output logic empty
);

	localparam int PTR_W = $clog2(DEPTH);

	word_t mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;

	assign full = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);
	assign popWord = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushWord;
	end

	// Pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	noPopEmpty: assert property (
		@(posedge clk) disable iff (!rstN) pop |-> !empty
	) else $error("instrQueue: pop while empty");

	noPushFull: assert property (
		@(posedge clk) disable iff (!rstN) push |-> !full
	) else $error("instrQueue: push while full");

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/10ps

module controlUnit import cpuTypesPkg::*;
(
	input instr_t instr,
	output logic dREN,
	output logic dWEN,
	output logic [1:0] aluSource,
	output aluop_t aluOP,
	output logic extendType,
	output logic [1:0] memToReg,
	output logic [1:0] nextPC,
	output logic [1:0] regDest,
	output logic regWrite,
	output logic branchFlag,
	output logic halt
);

	always_comb
	begin
		// Anything not listed stays an all-zero no-op
		dREN = 1'b0;
		dWEN = 1'b0;
		aluSource = 2'd0;
		aluOP = aluop_t'(4'd0);
		extendType = 1'b0;
		memToReg = 2'd0;
		nextPC = 2'd0;
		regDest = 2'd0;
		regWrite = 1'b0;
		branchFlag = 1'b0;
		halt = 1'b0;

		case (instr.rType.opcode)
			RTYPE:
			begin
				case (instr.rType.funct)
					SLL, SRL, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU:
					begin
						memToReg = 2'd1;
						regDest = 2'd1;
						regWrite = 1'b1;
					end
					JR:
					begin
						memToReg = 2'd1;
						regDest = 2'd1;
						nextPC = 2'd2;
					end
				endcase
				// Shifts take shamt as the second operand
				case (instr.rType.funct)
					SLL:
					begin
						aluSource = 2'd2;
						aluOP = ALU_SLL;
					end
					SRL:
					begin
						aluSource = 2'd2;
						aluOP = ALU_SRL;
					end
					ADDU: aluOP = ALU_ADD;
					SUBU: aluOP = ALU_SUB;
					AND: aluOP = ALU_AND;
					OR: aluOP = ALU_OR;
					XOR: aluOP = ALU_XOR;
					NOR: aluOP = ALU_NOR;
					SLT: aluOP = ALU_SLT;
					SLTU: aluOP = ALU_SLTU;
				endcase
			end
			ADDIU:
			begin
				aluSource = 2'd1;
				memToReg = 2'd1;
				extendType = 1'b1;
				aluOP = ALU_ADD;
				regWrite = 1'b1;
			end
			ANDI:
			begin
				aluSource = 2'd1;
				memToReg = 2'd1;
				aluOP = ALU_AND;
				regWrite = 1'b1;
			end
			ORI:
			begin
				aluSource = 2'd1;
				memToReg = 2'd1;
				aluOP = ALU_OR;
				regWrite = 1'b1;
			end
			XORI:
			begin
				aluSource = 2'd1;
				memToReg = 2'd1;
				aluOP = ALU_XOR;
				regWrite = 1'b1;
			end
			SLTI, SLTIU:
			begin
				aluSource = 2'd1;
				memToReg = 2'd1;
				extendType = 1'b1;
				aluOP = (instr.rType.opcode == SLTI) ? ALU_SLT : ALU_SLTU;
				regWrite = 1'b1;
			end
			BEQ, BNE:
			begin
				extendType = 1'b1;
				aluOP = ALU_SUB;
				nextPC = 2'd1;
				branchFlag = (instr.rType.opcode == BEQ);
			end
			LUI:
			begin
				memToReg = 2'd3;
				extendType = 1'b1;
				regWrite = 1'b1;
			end
			LW:
			begin
				dREN = 1'b1;
				aluSource = 2'd1;
				memToReg = 2'd2;
				extendType = 1'b1;
				aluOP = ALU_ADD;
				regWrite = 1'b1;
			end
			SW:
			begin
				dWEN = 1'b1;
				aluSource = 2'd1;
				extendType = 1'b1;
				aluOP = ALU_ADD;
			end
			J: nextPC = 2'd3;
			JAL:
			begin
				regWrite = 1'b1;
				nextPC = 2'd2;
				regDest = 2'd2;
			end
			HALT:
			begin
				// Both fields all ones
				if (6'(instr.rType.funct) == 6'(HALT))
					halt = 1'b1;
			end
		endcase
	end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module decodeStage import cpuTypesPkg::*;
(
	input logic clk,
	input logic rstN,
	output logic pop,
	input word_t popWord,
	input logic empty,
	output logic outReq,
	input logic outAck,
	output logic dREN,
	output logic dWEN,
	output logic [1:0] aluSource,
	output aluop_t aluOP,
	output logic [1:0] memToReg,
	output logic [1:0] nextPC,
	output logic regWrite,
	output logic branchFlag,
	output logic halt,
	output regbits_t rs,
	output regbits_t rt,
	output regbits_t destReg,
	output logic [4:0] shamt,
	output word_t immExt,
	output logic [25:0] jumpAddr
);

	instr_t instr;
	logic cuDREN;
	logic cuDWEN;
	logic [1:0] cuAluSource;
	aluop_t cuAluOP;
	logic cuExtendType;
	logic [1:0] cuMemToReg;
	logic [1:0] cuNextPC;
	logic [1:0] cuRegDest;
	logic cuRegWrite;
	logic cuBranchFlag;
	logic cuHalt;
	regbits_t nextDest;
	word_t nextImm;
	logic halted;

	assign instr = popWord;

	controlUnit cu (
		.instr(instr),
		.dREN(cuDREN),
		.dWEN(cuDWEN),
		.aluSource(cuAluSource),
		.aluOP(cuAluOP),
		.extendType(cuExtendType),
		.memToReg(cuMemToReg),
		.nextPC(cuNextPC),
		.regDest(cuRegDest),
		.regWrite(cuRegWrite),
		.branchFlag(cuBranchFlag),
		.halt(cuHalt)
	);

	always_comb
	begin
		case (cuRegDest)
			2'd1: nextDest = instr.rType.rd;
			2'd2: nextDest = regbits_t'(`REG_RA);
			default: nextDest = instr.iType.rt;
		endcase
	end

	assign nextImm = cuExtendType ? {{16{instr.iType.imm16[15]}}, instr.iType.imm16}
		: {16'h0000, instr.iType.imm16};

	// Next word only after the previous handshake has fully closed
	assign pop = !outReq && !outAck && !empty && !halted;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outReq <= 1'b0;
			halted <= 1'b0;
			dREN <= 1'b0;
			dWEN <= 1'b0;
			aluSource <= 2'd0;
			aluOP <= aluop_t'(4'd0);
			memToReg <= 2'd0;
			nextPC <= 2'd0;
			regWrite <= 1'b0;
			branchFlag <= 1'b0;
			halt <= 1'b0;
		end
		else
		begin
			if (pop)
			begin
				outReq <= 1'b1;
				dREN <= cuDREN;
				dWEN <= cuDWEN;
				aluSource <= cuAluSource;
				aluOP <= cuAluOP;
				memToReg <= cuMemToReg;
				nextPC <= cuNextPC;
				regWrite <= cuRegWrite;
				branchFlag <= cuBranchFlag;
				halt <= cuHalt;
			end
			else if (outReq && outAck)
			begin
				outReq <= 1'b0;
			end
			// Sticky once a HALT has been taken downstream
			if (outReq && outAck && halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			rs <= instr.rType.rs;
			rt <= instr.rType.rt;
			destReg <= nextDest;
			shamt <= instr.rType.shamt;
			immExt <= nextImm;
			jumpAddr <= instr.jType.addr26;
		end
	end

	// Consumer acknowledges only a word on offer
	ackWithReq: assert property (
		@(posedge clk) disable iff (!rstN)
		$rose(outAck) |-> outReq
	) else $error("decodeStage: outAck raised without outReq");

endmodule

//--- logic/decodeTop.sv
`timescale 1ns/10ps

module decodeTop import cpuTypesPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input word_t inInstr,
	output logic inAck,
	output logic outReq,
	input logic outAck,
	output logic dREN,
	output logic dWEN,
	output logic [1:0] aluSource,
	output aluop_t aluOP,
	output logic [1:0] memToReg,
	output logic [1:0] nextPC,
	output logic regWrite,
	output logic branchFlag,
	output logic halt,
	output regbits_t rs,
	output regbits_t rt,
	output regbits_t destReg,
	output logic [4:0] shamt,
	output word_t immExt,
	output logic [25:0] jumpAddr
);

	logic push;
	word_t pushWord;
	logic full;
	logic pop;
	word_t popWord;
	logic empty;

	instrIntake intake (
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inInstr(inInstr),
		.inAck(inAck),
		.push(push),
		.pushWord(pushWord),
		.full(full)
	);

	instrQueue queue (
		.clk(clk),
		.rstN(rstN),
		.push(push),
		.pushWord(pushWord),
		.pop(pop),
		.popWord(popWord),
		.full(full),
		.empty(empty)
	);

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.pop(pop),
		.popWord(popWord),
		.empty(empty),
		.outReq(outReq),
		.outAck(outAck),
		.dREN(dREN),
		.dWEN(dWEN),
		.aluSource(aluSource),
		.aluOP(aluOP),
		.memToReg(memToReg),
		.nextPC(nextPC),
		.regWrite(regWrite),
		.branchFlag(branchFlag),
		.halt(halt),
		.rs(rs),
		.rt(rt),
		.destReg(destReg),
		.shamt(shamt),
		.immExt(immExt),
		.jumpAddr(jumpAddr)
	);

endmodule

//--- test/decodeTopTb.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module decodeTopTb import cpuTypesPkg::*; ();

	// Result layout: 15 control bits, then rs, rt, destReg, shamt, immExt, jumpAddr
	localparam int RES_W = 93;
	localparam int CTRL_W = 15;
	localparam int HALT_BIT = RES_W - CTRL_W;
	localparam int WAIT_LIMIT = 400;
	localparam int AFTER_HALT = 3;

	localparam logic [5:0] OP_LIST [15] = '{RTYPE, ADDIU, ANDI, BEQ, BNE, LUI, LW, ORI, SLTI,
		SLTIU, SW, XORI, J, JAL, 6'h3e};
	localparam logic [5:0] I_LIST [11] = '{ADDIU, ANDI, BEQ, BNE, LUI, LW, ORI, SLTI, SLTIU,
		SW, XORI};
	localparam logic [5:0] FUNCT_LIST [12] = '{SLL, SRL, JR, ADDU, SUBU, AND, OR, XOR, NOR,
		SLT, SLTU, 6'h01};

	logic clk;
	logic rstN;
	logic inReq;
	word_t inInstr;
	logic inAck;
	logic outReq;
	logic outAck;
	logic dREN;
	logic dWEN;
	logic [1:0] aluSource;
	aluop_t aluOP;
	logic [1:0] memToReg;
	logic [1:0] nextPC;
	logic regWrite;
	logic branchFlag;
	logic halt;
	regbits_t rs;
	regbits_t rt;
	regbits_t destReg;
	logic [4:0] shamt;
	word_t immExt;
	logic [25:0] jumpAddr;

	logic [RES_W-1:0] actVec;
	logic [RES_W-1:0] expNow = '0;
	logic haltSeen = 1'b0;
	word_t stim [$];
	logic [RES_W-1:0] expQ [$];
	int mismatchCount = 0;
	int protocolErrors = 0;
	int otherErrors = 0;
	int fullCycles = 0;

	decodeTop UUT (
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inInstr(inInstr),
		.inAck(inAck),
		.outReq(outReq),
		.outAck(outAck),
		.dREN(dREN),
		.dWEN(dWEN),
		.aluSource(aluSource),
		.aluOP(aluOP),
		.memToReg(memToReg),
		.nextPC(nextPC),
		.regWrite(regWrite),
		.branchFlag(branchFlag),
		.halt(halt),
		.rs(rs),
		.rt(rt),
		.destReg(destReg),
		.shamt(shamt),
		.immExt(immExt),
		.jumpAddr(jumpAddr)
	);

	assign actVec = {dREN, dWEN, aluSource, aluOP, memToReg, nextPC, regWrite, branchFlag,
		halt, rs, rt, destReg, shamt, immExt, jumpAddr};

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (UUT.full)
			fullCycles++;
	end

	resultCheck: assert property (
		@(posedge clk) disable iff (!rstN) $rose(outReq) |-> actVec == expNow
	) else begin
		mismatchCount++;
		$display("Mismatch at %0t: expected %h, got %h", $time, $sampled(expNow),
			$sampled(actVec));
	end

	resetCheck: assert property (
		@(posedge clk) !rstN |=> !inAck && !outReq && actVec[RES_W-1 -: CTRL_W] == '0
	) else begin
		mismatchCount++;
		$display("Mismatch at %0t: handshake or control outputs not zero after reset", $time);
	end

	haltCheck: assert property (
		@(posedge clk) disable iff (!rstN) haltSeen |-> !outReq
	) else begin
		protocolErrors++;
		$display("Decode stage offered a word after HALT was delivered, at %0t", $time);
	end

	// Intake must not acknowledge into a full queue
	fullCheck: assert property (
		@(posedge clk) disable iff (!rstN) UUT.full && !inAck |=> !inAck
	) else begin
		protocolErrors++;
		$display("Word acknowledged while the queue was full, at %0t", $time);
	end

	// Expected decode of one word
	function automatic logic [RES_W-1:0] expectedFor(input word_t w);
		logic [5:0] op;
		logic [5:0] fn;
		logic rdEn;
		logic wrEn;
		logic [1:0] src;
		logic [3:0] alu;
		logic [1:0] m2r;
		logic [1:0] npc;
		logic [1:0] dstSel;
		logic regWr;
		logic br;
		logic hlt;
		logic sext;
		logic [4:0] dst;
		word_t imm;
		op = w[31:26];
		fn = w[5:0];
		{rdEn, wrEn, src, alu, m2r, npc, dstSel, regWr, br, hlt, sext} = '0;
		case (op)
			RTYPE:
			begin
				if (fn inside {SLL, SRL, JR, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU})
				begin
					m2r = 2'd1;
					dstSel = 2'd1;
					regWr = (fn != JR);
					npc = (fn == JR) ? 2'd2 : 2'd0;
				end
				case (fn)
					SLL: {src, alu} = {2'd2, 4'(ALU_SLL)};
					SRL: {src, alu} = {2'd2, 4'(ALU_SRL)};
					ADDU: alu = ALU_ADD;
					SUBU: alu = ALU_SUB;
					AND: alu = ALU_AND;
					OR: alu = ALU_OR;
					XOR: alu = ALU_XOR;
					NOR: alu = ALU_NOR;
					SLT: alu = ALU_SLT;
					SLTU: alu = ALU_SLTU;
					default: alu = 4'd0;
				endcase
			end
			ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LW:
			begin
				src = 2'd1;
				m2r = (op == LW) ? 2'd2 : 2'd1;
				regWr = 1'b1;
				rdEn = (op == LW);
				// Logical immediates are zero-extended
				sext = !(op inside {ANDI, ORI, XORI});
				case (op)
					SLTI: alu = ALU_SLT;
					SLTIU: alu = ALU_SLTU;
					ANDI: alu = ALU_AND;
					ORI: alu = ALU_OR;
					XORI: alu = ALU_XOR;
					default: alu = ALU_ADD;
				endcase
			end
			SW:
			begin
				wrEn = 1'b1;
				src = 2'd1;
				sext = 1'b1;
				alu = ALU_ADD;
			end
			BEQ, BNE:
			begin
				sext = 1'b1;
				alu = ALU_SUB;
				npc = 2'd1;
				br = (op == BEQ);
			end
			LUI:
			begin
				m2r = 2'd3;
				sext = 1'b1;
				regWr = 1'b1;
			end
			J: npc = 2'd3;
			JAL:
			begin
				regWr = 1'b1;
				npc = 2'd2;
				dstSel = 2'd2;
			end
			HALT: hlt = (fn == 6'h3f);
			default: hlt = 1'b0;
		endcase
		case (dstSel)
			2'd1: dst = w[15:11];
			2'd2: dst = 5'(`REG_RA);
			default: dst = w[20:16];
		endcase
		imm = sext ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
		return {rdEn, wrEn, src, alu, m2r, npc, regWr, br, hlt, w[25:21], w[20:16], dst,
			w[10:6], imm, w[25:0]};
	endfunction

	function automatic word_t randomWord();
		word_t w;
		w = {OP_LIST[$urandom_range(14, 0)], 26'($urandom)};
		if (w[31:26] == RTYPE)
			w[5:0] = FUNCT_LIST[$urandom_range(11, 0)];
		return w;
	endfunction

	task automatic loadDirectedWords();
		for (int i = 0; i < 12; i++)
			stim.push_back({RTYPE, 20'($urandom), FUNCT_LIST[i]});
		// Each I-type once with a clear and once with a set sign bit
		for (int i = 0; i < 11; i++)
		begin
			stim.push_back({I_LIST[i], 10'($urandom), 1'b0, 15'($urandom)});
			stim.push_back({I_LIST[i], 10'($urandom), 1'b1, 15'($urandom)});
		end
		stim.push_back({J, 26'($urandom)});
		stim.push_back({JAL, 26'($urandom)});
		stim.push_back({6'h3e, 26'($urandom)});
		stim.push_back({HALT, 20'($urandom), 6'h00});
	endtask

	// Fetch side of the four-phase input handshake
	task automatic sendWord(input word_t w, input int maxGap);
		int waited;
		repeat ($urandom_range(maxGap, 0))
		begin
			@(posedge clk);
			#1;
		end
		inInstr = w;
		inReq = 1'b1;
		expQ.push_back(expectedFor(w));
		waited = 0;
		while (!inAck && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!inAck)
		begin
			otherErrors++;
			$display("Timeout waiting for inAck at %0t", $time);
			inReq = 1'b0;
			return;
		end
		inReq = 1'b0;
		waited = 0;
		while (inAck && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (inAck)
		begin
			otherErrors++;
			$display("Timeout waiting for inAck to drop at %0t", $time);
		end
	endtask

	task automatic sendAll(input int maxGap);
		foreach (stim[i])
			sendWord(stim[i], maxGap);
		stim.delete();
	endtask

	// Downstream consumer with random acknowledge delay
	task automatic receiveWords(input int count, input int minDelay, input int maxDelay);
		int waited;
		for (int n = 0; n < count; n++)
		begin
			waited = 0;
			while (!outReq && waited < WAIT_LIMIT)
			begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (!outReq)
			begin
				otherErrors++;
				$display("Timeout waiting for outReq at %0t", $time);
				return;
			end
			if (expQ.size() == 0)
			begin
				otherErrors++;
				$display("Word offered downstream with none outstanding at %0t", $time);
			end
			else
				expNow = expQ.pop_front();
			repeat ($urandom_range(maxDelay, minDelay))
			begin
				@(posedge clk);
				#1;
			end
			outAck = 1'b1;
			waited = 0;
			while (outReq && waited < WAIT_LIMIT)
			begin
				@(posedge clk);
				#1;
				waited++;
			end
			outAck = 1'b0;
			if (outReq)
			begin
				otherErrors++;
				$display("Timeout waiting for outReq to drop at %0t", $time);
				return;
			end
			if (expNow[HALT_BIT])
				haltSeen = 1'b1;
		end
	endtask

	task automatic runBatch(input int maxGap, input int minDelay, input int maxDelay);
		int count;
		count = stim.size();
		fork
			sendAll(maxGap);
			receiveWords(count, minDelay, maxDelay);
		join
		if (expQ.size() != 0)
		begin
			otherErrors++;
			$display("%0d sent words never came out of the decode stage", expQ.size());
			expQ.delete();
		end
	endtask

	initial
	begin
		void'($urandom(32'ha17d7f22));
		rstN = 1'b0;
		inReq = 1'b0;
		inInstr = '0;
		outAck = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;

		loadDirectedWords();
		runBatch(3, 0, 3);

		repeat (40) stim.push_back(randomWord());
		runBatch(2, 0, 2);

		// Slow consumer so the queue fills up
		repeat (12) stim.push_back(randomWord());
		runBatch(0, 15, 25);
		if (fullCycles == 0)
		begin
			otherErrors++;
			$display("Queue never reached full under back-pressure");
		end

		stim.push_back({HALT, 20'($urandom), 6'h3f});
		repeat (AFTER_HALT) stim.push_back(randomWord());
		fork
			sendAll(2);
			receiveWords(1, 0, 3);
		join
		repeat (40) @(posedge clk);
		#1;
		if (expQ.size() != AFTER_HALT)
		begin
			otherErrors++;
			$display("Decode stage consumed words after HALT, %0d of %0d left", expQ.size(),
				AFTER_HALT);
		end

		$display("Errors: %0d mismatch, %0d protocol, %0d other", mismatchCount,
			protocolErrors, otherErrors);
		if (mismatchCount == 0 && protocolErrors == 0 && otherErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/cpuTypesPkg.sv
logic/instrIntake.sv
logic/instrQueue.sv
logic/controlUnit.sv
logic/decodeStage.sv
logic/decodeTop.sv
test/decodeTopTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= decodeTopTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
